// ==== Bender.yml ====
package:
  name: pktgen

export_include_dirs:
  - source

sources:
  - files:
      - source/pktgen_pkg.sv
      - source/pktgen_regs.sv
      - source/pktgen_sequencer.sv
      - source/ipv4_frame_builder.sv
      - source/pktgen_top.sv

  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_pktgen.sv

// ==== project.f ====
+incdir+source
source/pktgen_pkg.sv
source/pktgen_regs.sv
source/pktgen_sequencer.sv
source/ipv4_frame_builder.sv
source/pktgen_top.sv
sim/tb_clock.sv
sim/tb_pktgen.sv

// ==== sim/tb_clock.sv ====
// Free-running clock, starts low, 40 ns period by default

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_ifc_avmm
);

    initial begin
        clk_ifc_avmm = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_ifc_avmm = ~clk_ifc_avmm;
        end
    end

endmodule

// ==== sim/tb_pktgen.sv ====
// Directed tests of pktgen_top. Outputs are sampled at the rising edge before
// the DUT updates them; tready rests high while no frame is being collected.

`timescale 1ns/1ns
`include "pktgen_cfg.svh"

module tb_pktgen import pktgen_pkg::*; ();

    localparam int FRAME_BYTES = `PKTGEN_ETH_HDR_BYTES + `PKTGEN_IP_HDR_BYTES
                                 + 4 * `PKTGEN_PAYLOAD_WORDS;
    localparam int FIRST_VALID_CYCLES = 5;
    localparam int WAIT_LIMIT = 4000;

    logic        clk_ifc_avmm;
    logic        reset;
    logic [4:0]  address;
    logic        write;
    logic [31:0] writedata;
    logic        read;
    logic        tready;
    logic [31:0] readdata;
    logic [7:0]  tdata;
    logic        tvalid;
    logic        tlast;

    // Header fields as last written, input of the reference model
    logic [7:0]  cfg_tos;
    logic [7:0]  cfg_ttl;
    logic [7:0]  cfg_proto;
    logic [31:0] cfg_src_ip;
    logic [31:0] cfg_dst_ip;
    logic [47:0] cfg_dst_mac;
    logic [15:0] cfg_ident;

    logic [7:0]  rx_bytes[$];
    logic [7:0]  exp_bytes[$];
    int          rand_seed;

    tb_clock u_clock (
        .clk_ifc_avmm (clk_ifc_avmm)
    );

    pktgen_top u_dut (
        .clk_ifc_avmm (clk_ifc_avmm),
        .reset        (reset),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .read         (read),
        .tready       (tready),
        .readdata     (readdata),
        .tdata        (tdata),
        .tvalid       (tvalid),
        .tlast        (tlast)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checking and bus access

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic bus_write(input reg_addr_t addr, input logic [31:0] data);
        @(posedge clk_ifc_avmm);
        address   <= addr;
        writedata <= data;
        write     <= 1'b1;
        @(posedge clk_ifc_avmm);
        write <= 1'b0;
    endtask

    // Read latency of one cycle
    task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk_ifc_avmm);
        address <= addr;
        read    <= 1'b1;
        @(posedge clk_ifc_avmm);
        read <= 1'b0;
        @(posedge clk_ifc_avmm);
        data = readdata;
    endtask

    task automatic read_check(input reg_addr_t addr, input logic [31:0] expected);
        logic [31:0] data;
        bus_read(addr, data);
        check_value(addr.name(), data, expected);
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          tries;
        tries  = 0;
        status = 32'hffff_ffff;
        while (status != 32'd0) begin
            if (tries == 500) begin
                $display("timeout: the sequencer never returned to idle");
                stop_on_failure();
            end
            bus_read(REG_STATUS, status);
            tries++;
        end
    endtask

    task automatic wait_for_valid();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_ifc_avmm);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: tvalid never went high");
                stop_on_failure();
            end
        end while (tvalid !== 1'b1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Header setup and reference model

    task automatic configure_header(input logic [15:0] ident);
        cfg_tos     = 8'hb9;    // DSCP 46, ECN 1
        cfg_ttl     = 8'($urandom_range(255, 1));
        cfg_proto   = 8'd17;
        cfg_src_ip  = $urandom;
        cfg_dst_ip  = $urandom;
        cfg_dst_mac = {16'h0201, 32'($urandom)};
        cfg_ident   = ident;
        bus_write(REG_TOS, {24'd0, cfg_tos});
        bus_write(REG_TTL_PROTO, {16'd0, cfg_ttl, cfg_proto});
        bus_write(REG_SRC_IP, cfg_src_ip);
        bus_write(REG_DST_IP, cfg_dst_ip);
        bus_write(REG_DST_MAC_HI, {16'd0, cfg_dst_mac[47:32]});
        bus_write(REG_DST_MAC_LO, cfg_dst_mac[31:0]);
        bus_write(REG_IDENT_BASE, {16'd0, cfg_ident});
    endtask

    task automatic build_expected_frame(input logic [31:0] pkt);
        logic [15:0] words [10];
        logic [31:0] sum;
        logic [47:0] src_mac;
        src_mac  = `PKTGEN_SRC_MAC;
        words[0] = {8'h45, cfg_tos};
        words[1] = 16'(`PKTGEN_IP_HDR_BYTES + 4 * `PKTGEN_PAYLOAD_WORDS);
        words[2] = cfg_ident + pkt[15:0];
        words[3] = 16'h4000;
        words[4] = {cfg_ttl, cfg_proto};
        words[5] = 16'h0000;
        words[6] = cfg_src_ip[31:16];
        words[7] = cfg_src_ip[15:0];
        words[8] = cfg_dst_ip[31:16];
        words[9] = cfg_dst_ip[15:0];
        // One's-complement sum, carries folded back in
        sum = 32'd0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + words[i];
        end
        while (sum[31:16] != 16'd0) begin
            sum = sum[15:0] + sum[31:16];
        end
        words[5] = ~sum[15:0];

        exp_bytes = {};
        for (int i = 5; i >= 0; i--) begin
            exp_bytes.push_back(cfg_dst_mac[i*8 +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            exp_bytes.push_back(src_mac[i*8 +: 8]);
        end
        exp_bytes.push_back(8'h08);
        exp_bytes.push_back(8'h00);
        for (int i = 0; i < 10; i++) begin
            exp_bytes.push_back(words[i][15:8]);
            exp_bytes.push_back(words[i][7:0]);
        end
        for (int w = 0; w < `PKTGEN_PAYLOAD_WORDS; w++) begin
            for (int b = 3; b >= 0; b--) begin
                exp_bytes.push_back(pkt[b*8 +: 8]);
            end
        end
    endtask

    task automatic compare_frame(input logic [31:0] pkt);
        build_expected_frame(pkt);
        check_value("frame length", rx_bytes.size(), exp_bytes.size());
        for (int i = 0; i < exp_bytes.size(); i++) begin
            check_value($sformatf("tdata of byte %0d, packet %0d", i, pkt),
                        rx_bytes[i], exp_bytes[i]);
        end
    endtask

    // Gathers one frame up to tlast; wait_cycles counts edges until tvalid
    task automatic collect_frame(input bit random_ready, output int wait_cycles);
        int         cycles;
        bit         done;
        bit         stalled;
        logic [7:0] held_data;
        logic       held_last;
        rx_bytes    = {};
        cycles      = 0;
        wait_cycles = -1;
        done        = 1'b0;
        stalled     = 1'b0;
        while (!done) begin
            @(posedge clk_ifc_avmm);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout: no complete frame on the output stream");
                stop_on_failure();
            end
            // Stalled byte must not move
            if (stalled) begin
                check_value("tvalid", tvalid, 1'b1);
                check_value("tdata", tdata, held_data);
                check_value("tlast", tlast, held_last);
            end
            if (tvalid && wait_cycles < 0) begin
                wait_cycles = cycles;
            end
            stalled   = tvalid && !tready;
            held_data = tdata;
            held_last = tlast;
            if (tvalid && tready) begin
                rx_bytes.push_back(tdata);
                done = tlast;
            end
            if (random_ready && !done) begin
                tready <= ($urandom_range(3, 0) != 0);
            end else begin
                tready <= 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic test_reset_readback();
        logic [31:0] data;
        check_value("tvalid", tvalid, 1'b0);
        read_check(REG_STATUS, 32'd0);
        read_check(REG_REMAINING, 32'd0);
        read_check(REG_TX_CNT_LO, 32'd0);
        configure_header(16'h1200);
        read_check(REG_TOS, {24'd0, cfg_tos});
        read_check(REG_TTL_PROTO, {16'd0, cfg_ttl, cfg_proto});
        read_check(REG_SRC_IP, cfg_src_ip);
        read_check(REG_DST_IP, cfg_dst_ip);
        read_check(REG_DST_MAC_HI, {16'd0, cfg_dst_mac[47:32]});
        read_check(REG_DST_MAC_LO, cfg_dst_mac[31:0]);
        read_check(REG_IDENT_BASE, {16'd0, cfg_ident});
        bus_read(5'd10, data);
        check_value("readdata of unmapped address 10", data, 32'd0);
    endtask

    task automatic test_single_frame();
        int wait_cycles;
        bus_write(REG_NUM_PACKETS, 32'd1);
        bus_write(REG_INTERVAL, 32'd0);
        bus_write(REG_CTRL, 32'h1);
        collect_frame(1'b0, wait_cycles);
        // bus_write returns one edge after the write cycle
        check_value("first tvalid latency", wait_cycles + 1, FIRST_VALID_CYCLES);
        check_value("tlast byte position", rx_bytes.size(), FRAME_BYTES);
        compare_frame(32'd0);
        wait_idle();
    endtask

    task automatic test_multi_frame();
        int wait_cycles;
        int interval;
        interval = 8;
        // Base near the top so identification wraps
        configure_header(16'hfffe);
        bus_write(REG_NUM_PACKETS, 32'd3);
        bus_write(REG_INTERVAL, interval);
        bus_write(REG_CTRL, 32'h1);
        for (int i = 0; i < 3; i++) begin
            collect_frame(1'b0, wait_cycles);
            if (i > 0 && wait_cycles - 1 < interval) begin
                $display("only %0d idle cycles before frame %0d, interval is %0d",
                         wait_cycles - 1, i, interval);
                stop_on_failure();
            end
            compare_frame(i);
            check_value("identification", {rx_bytes[18], rx_bytes[19]}, 16'(16'hfffe + i));
        end
        wait_idle();
        check_value("tvalid", tvalid, 1'b0);
        read_check(REG_TX_CNT_LO, 32'd3);
        read_check(REG_TX_CNT_HI, 32'd0);
        read_check(REG_REMAINING, 32'd0);
        read_check(REG_STATUS, 32'd0);
    endtask

    task automatic test_back_pressure();
        int wait_cycles;
        configure_header(16'($urandom));
        bus_write(REG_NUM_PACKETS, 32'd2);
        bus_write(REG_INTERVAL, 32'd3);
        bus_write(REG_CTRL, 32'h1);
        for (int i = 0; i < 2; i++) begin
            collect_frame(1'b1, wait_cycles);
            compare_frame(i);
        end
        wait_idle();
        read_check(REG_TX_CNT_LO, 32'd2);
    endtask

    task automatic test_continuous();
        int wait_cycles;
        bus_write(REG_NUM_PACKETS, 32'd0);
        bus_write(REG_INTERVAL, 32'd2);
        bus_write(REG_CTRL, 32'h3);
        for (int i = 0; i < 3; i++) begin
            collect_frame(1'b0, wait_cycles);
            compare_frame(i);
        end
        // Stop lands while frame 3 is on the wire
        fork
            collect_frame(1'b0, wait_cycles);
            begin
                wait_for_valid();
                bus_write(REG_CTRL, 32'h6);
            end
        join
        compare_frame(32'd3);
        repeat (150) begin
            @(posedge clk_ifc_avmm);
            check_value("tvalid", tvalid, 1'b0);
        end
        wait_idle();
        read_check(REG_TX_CNT_LO, 32'd4);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        reset       = 1'b1;
        address     = '0;
        write       = 1'b0;
        writedata   = '0;
        read        = 1'b0;
        tready      = 1'b1;
        rand_seed   = $urandom(32'h2233);

        repeat (16) @(posedge clk_ifc_avmm);
        reset <= 1'b0;
        @(posedge clk_ifc_avmm);

        test_reset_readback();
        test_single_frame();
        test_multi_frame();
        test_back_pressure();
        test_continuous();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== source/ipv4_frame_builder.sv ====
// Ethernet II frame with a plain IPv4 header: no options, DF set, offset zero.
// packet_id must stay stable from build_stb until frame_stb.

`timescale 1ns/1ns
`include "pktgen_cfg.svh"

module ipv4_frame_builder import pktgen_pkg::*; (
    input  logic        clk_ifc_avmm,
    input  logic        reset,
    input  logic        build_stb,
    input  logic [31:0] packet_id,
    input  logic [5:0]  dscp,
    input  logic [1:0]  ecn,
    input  logic [7:0]  ttl,
    input  logic [7:0]  protocol,
    input  logic [31:0] src_ip,
    input  logic [31:0] dst_ip,
    input  logic [47:0] dst_mac,
    input  logic [15:0] ident_base,
    input  logic        tready,
    output logic        frame_stb,
    output logic [7:0]  tdata,
    output logic        tvalid,
    output logic        tlast
);

    localparam int HDR_BYTES   = `PKTGEN_ETH_HDR_BYTES + `PKTGEN_IP_HDR_BYTES;
    localparam int FRAME_BYTES = HDR_BYTES + 4 * `PKTGEN_PAYLOAD_WORDS;
    localparam int IDX_W       = $clog2(FRAME_BYTES);
    localparam logic [15:0] TOTAL_LEN = 16'(`PKTGEN_IP_HDR_BYTES + 4 * `PKTGEN_PAYLOAD_WORDS);
    // Flags 010 (don't fragment), offset 0
    localparam logic [15:0] FLAGS_FRAG = 16'h4000;

    build_state_t            state;
    logic [IDX_W-1:0]        byte_idx;
    logic [IDX_W-1:0]        pay_idx;
    logic [47:0]             lat_dst_mac;
    logic [7:0]              lat_tos;
    logic [15:0]             lat_ident;
    logic [7:0]              lat_ttl;
    logic [7:0]              lat_proto;
    logic [31:0]             lat_src_ip;
    logic [31:0]             lat_dst_ip;
    logic [15:0]             hdr_csum;
    logic [15:0]             ip_words [10];
    logic [19:0]             csum_sum;
    logic [16:0]             csum_fold1;
    logic [15:0]             csum_fold2;
    logic [8*HDR_BYTES-1:0]  hdr_vec;

    ////////////////////////////////////////////////////////////////////////////
    // Header checksum, evaluated from the latched fields during B_SUM

    always_comb begin
        ip_words[0] = {8'h45, lat_tos};
        ip_words[1] = TOTAL_LEN;
        ip_words[2] = lat_ident;
        ip_words[3] = FLAGS_FRAG;
        ip_words[4] = {lat_ttl, lat_proto};
        ip_words[5] = 16'h0000;
        ip_words[6] = lat_src_ip[31:16];
        ip_words[7] = lat_src_ip[15:0];
        ip_words[8] = lat_dst_ip[31:16];
        ip_words[9] = lat_dst_ip[15:0];
        csum_sum = '0;
        for (int i = 0; i < 10; i++) begin
            csum_sum = csum_sum + 20'(ip_words[i]);
        end
        // End-around carry, twice covers the worst case
        csum_fold1 = {1'b0, csum_sum[15:0]} + {13'd0, csum_sum[19:16]};
        csum_fold2 = csum_fold1[15:0] + {15'd0, csum_fold1[16]};
    end

    // Whole header, first byte on the wire in the top bits
    assign hdr_vec = {lat_dst_mac, `PKTGEN_SRC_MAC, 16'h0800,
                      8'h45, lat_tos, TOTAL_LEN, lat_ident, FLAGS_FRAG,
                      lat_ttl, lat_proto, hdr_csum, lat_src_ip, lat_dst_ip};

    assign pay_idx = byte_idx - IDX_W'(HDR_BYTES);

    // Byte select, payload words go out MSB first
    always_comb begin
        if (byte_idx < IDX_W'(HDR_BYTES)) begin
            tdata = hdr_vec[(HDR_BYTES - 1 - byte_idx) * 8 +: 8];
        end else begin
            tdata = packet_id[(3 - pay_idx[1:0]) * 8 +: 8];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Header latch

    always_ff @(posedge clk_ifc_avmm) begin
        if (state == B_IDLE && build_stb) begin
            lat_dst_mac <= dst_mac;
            lat_tos     <= {dscp, ecn};
            lat_ident   <= ident_base + packet_id[15:0];
            lat_ttl     <= ttl;
            lat_proto   <= protocol;
            lat_src_ip  <= src_ip;
            lat_dst_ip  <= dst_ip;
        end
        if (state == B_SUM) begin
            hdr_csum <= ~csum_fold2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stream control

    always_ff @(posedge clk_ifc_avmm) begin
        if (reset) begin
            state     <= B_IDLE;
            byte_idx  <= '0;
            tvalid    <= 1'b0;
            tlast     <= 1'b0;
            frame_stb <= 1'b0;
        end else begin
            frame_stb <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (build_stb) begin
                        state <= B_SUM;
                    end
                end
                B_SUM: begin
                    byte_idx <= '0;
                    tvalid   <= 1'b1;
                    tlast    <= 1'b0;
                    state    <= B_STREAM;
                end
                B_STREAM: begin
                    if (tvalid && tready) begin
                        if (tlast) begin
                            tvalid    <= 1'b0;
                            tlast     <= 1'b0;
                            frame_stb <= 1'b1;
                            state     <= B_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            tlast    <= (byte_idx == IDX_W'(FRAME_BYTES - 2));
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

// ==== source/pktgen_cfg.svh ====
// Build-time settings of the packet generator. The payload size and source MAC
// are fixed at elaboration and cannot be changed from software.

`ifndef PKTGEN_CFG_SVH
`define PKTGEN_CFG_SVH

// Frame layout
`define PKTGEN_PAYLOAD_WORDS 10
`define PKTGEN_SRC_MAC       48'haa_aa_aa_aa_bb_aa
`define PKTGEN_IP_HDR_BYTES  20
`define PKTGEN_ETH_HDR_BYTES 14

// Avalon-MM word addresses, configuration
`define PKTGEN_ADDR_CTRL         5'd0
`define PKTGEN_ADDR_NUM_PACKETS  5'd1
`define PKTGEN_ADDR_INTERVAL     5'd2
`define PKTGEN_ADDR_TOS          5'd3
`define PKTGEN_ADDR_TTL_PROTO    5'd4
`define PKTGEN_ADDR_SRC_IP       5'd5
`define PKTGEN_ADDR_DST_IP       5'd6
`define PKTGEN_ADDR_DST_MAC_HI   5'd7
`define PKTGEN_ADDR_DST_MAC_LO   5'd8
`define PKTGEN_ADDR_IDENT_BASE   5'd9

// Status, read only
`define PKTGEN_ADDR_STATUS       5'd16
`define PKTGEN_ADDR_REMAINING    5'd17
`define PKTGEN_ADDR_TX_CNT_LO    5'd18
`define PKTGEN_ADDR_TX_CNT_HI    5'd19

`endif

// ==== source/pktgen_pkg.sv ====
// Shared types of the packet generator. Register values come from pktgen_cfg.svh.

`include "pktgen_cfg.svh"

package pktgen_pkg;

    // Send schedule, shown in the low byte of the status register
    typedef enum logic [7:0] {
        SEQ_IDLE = 8'd0,
        SEQ_SEND = 8'd1,
        SEQ_GAP  = 8'd2
    } seq_state_t;

    // Frame builder phases
    typedef enum logic [1:0] {
        B_IDLE,
        B_SUM,
        B_STREAM
    } build_state_t;

    // Register map, word addresses
    typedef enum logic [4:0] {
        REG_CTRL        = `PKTGEN_ADDR_CTRL,
        REG_NUM_PACKETS = `PKTGEN_ADDR_NUM_PACKETS,
        REG_INTERVAL    = `PKTGEN_ADDR_INTERVAL,
        REG_TOS         = `PKTGEN_ADDR_TOS,
        REG_TTL_PROTO   = `PKTGEN_ADDR_TTL_PROTO,
        REG_SRC_IP      = `PKTGEN_ADDR_SRC_IP,
        REG_DST_IP      = `PKTGEN_ADDR_DST_IP,
        REG_DST_MAC_HI  = `PKTGEN_ADDR_DST_MAC_HI,
        REG_DST_MAC_LO  = `PKTGEN_ADDR_DST_MAC_LO,
        REG_IDENT_BASE  = `PKTGEN_ADDR_IDENT_BASE,
        REG_STATUS      = `PKTGEN_ADDR_STATUS,
        REG_REMAINING   = `PKTGEN_ADDR_REMAINING,
        REG_TX_CNT_LO   = `PKTGEN_ADDR_TX_CNT_LO,
        REG_TX_CNT_HI   = `PKTGEN_ADDR_TX_CNT_HI
    } reg_addr_t;

endpackage

// ==== source/pktgen_regs.sv ====
// Avalon-MM slave without waitrequest, read latency 1. Header fields must stay
// unchanged while the generator is active; they feed the builder directly.

`timescale 1ns/1ns

module pktgen_regs import pktgen_pkg::*; (
    input  logic        clk_ifc_avmm,
    input  logic        reset,
    input  logic [4:0]  address,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic        read,
    input  seq_state_t  seq_state,
    input  logic [31:0] remaining,
    input  logic [63:0] tx_cnt,
    output logic [31:0] readdata,
    output logic        start_stb,
    output logic        stop_stb,
    output logic        continuous,
    output logic [31:0] num_packets,
    output logic [15:0] interval,
    output logic [5:0]  dscp,
    output logic [1:0]  ecn,
    output logic [7:0]  ttl,
    output logic [7:0]  protocol,
    output logic [31:0] src_ip,
    output logic [31:0] dst_ip,
    output logic [47:0] dst_mac,
    output logic [15:0] ident_base
);

    reg_addr_t   reg_addr;
    logic [31:0] rd_mux;

    assign reg_addr = reg_addr_t'(address);

    ////////////////////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge clk_ifc_avmm) begin
        if (reset) begin
            start_stb   <= 1'b0;
            stop_stb    <= 1'b0;
            continuous  <= 1'b0;
            num_packets <= '0;
            interval    <= '0;
            dscp        <= '0;
            ecn         <= '0;
            ttl         <= '0;
            protocol    <= '0;
            src_ip      <= '0;
            dst_ip      <= '0;
            dst_mac     <= '0;
            ident_base  <= '0;
        end else begin
            // Strobes last one cycle
            start_stb <= 1'b0;
            stop_stb  <= 1'b0;
            if (write) begin
                case (reg_addr)
                    REG_CTRL: begin
                        start_stb  <= writedata[0];
                        continuous <= writedata[1];
                        stop_stb   <= writedata[2];
                    end
                    REG_NUM_PACKETS: num_packets <= writedata;
                    REG_INTERVAL:    interval <= writedata[15:0];
                    REG_TOS: begin
                        dscp <= writedata[7:2];
                        ecn  <= writedata[1:0];
                    end
                    REG_TTL_PROTO: begin
                        ttl      <= writedata[15:8];
                        protocol <= writedata[7:0];
                    end
                    REG_SRC_IP:     src_ip <= writedata;
                    REG_DST_IP:     dst_ip <= writedata;
                    REG_DST_MAC_HI: dst_mac[47:32] <= writedata[15:0];
                    REG_DST_MAC_LO: dst_mac[31:0] <= writedata;
                    REG_IDENT_BASE: ident_base <= writedata[15:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side

    always_comb begin
        case (reg_addr)
            REG_TOS:        rd_mux = {24'd0, dscp, ecn};
            REG_TTL_PROTO:  rd_mux = {16'd0, ttl, protocol};
            REG_SRC_IP:     rd_mux = src_ip;
            REG_DST_IP:     rd_mux = dst_ip;
            REG_DST_MAC_HI: rd_mux = {16'd0, dst_mac[47:32]};
            REG_DST_MAC_LO: rd_mux = dst_mac[31:0];
            REG_IDENT_BASE: rd_mux = {16'd0, ident_base};
            // Bit 31 flags any non-idle state
            REG_STATUS:     rd_mux = {seq_state != SEQ_IDLE, 23'd0, seq_state};
            REG_REMAINING:  rd_mux = remaining;
            REG_TX_CNT_LO:  rd_mux = tx_cnt[31:0];
            REG_TX_CNT_HI:  rd_mux = tx_cnt[63:32];
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (reset) begin
            readdata <= '0;
        end else if (read) begin
            readdata <= rd_mux;
        end
    end

endmodule

// ==== source/pktgen_sequencer.sv ====
// Send schedule. Only frame_stb ends a frame, so back-pressure just stretches it.
// A stop ends continuous mode after the frame in flight; normal mode ignores it.

`timescale 1ns/1ns

module pktgen_sequencer import pktgen_pkg::*; (
    input  logic        clk_ifc_avmm,
    input  logic        reset,
    input  logic        start_stb,
    input  logic        stop_stb,
    input  logic        continuous,
    input  logic [31:0] num_packets,
    input  logic [15:0] interval,
    input  logic        frame_stb,
    output seq_state_t  seq_state,
    output logic [31:0] remaining,
    output logic [63:0] tx_cnt,
    output logic        build_stb,
    output logic [31:0] packet_id
);

    logic [15:0] gap_cnt;
    logic        stop_seen;
    logic [31:0] rem_eval;
    logic        finish;

    // Remaining count as it will be once the current frame is accounted for
    always_comb begin
        rem_eval = remaining;
        if (seq_state == SEQ_SEND && !continuous) begin
            rem_eval = remaining - 32'd1;
        end
        if (continuous) begin
            finish = stop_seen | stop_stb;
        end else begin
            finish = (rem_eval == '0);
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (reset) begin
            seq_state <= SEQ_IDLE;
            remaining <= '0;
            tx_cnt    <= '0;
            packet_id <= '0;
            gap_cnt   <= '0;
            stop_seen <= 1'b0;
            build_stb <= 1'b0;
        end else begin
            build_stb <= 1'b0;
            if (stop_stb && seq_state != SEQ_IDLE) begin
                stop_seen <= 1'b1;
            end

            case (seq_state)
                SEQ_IDLE: begin
                    if (start_stb) begin
                        remaining <= num_packets;
                        packet_id <= '0;
                        tx_cnt    <= '0;
                        stop_seen <= 1'b0;
                        // Nothing to send in normal mode with zero packets
                        if (num_packets != '0 || continuous) begin
                            build_stb <= 1'b1;
                            seq_state <= SEQ_SEND;
                        end
                    end
                end

                SEQ_SEND: begin
                    if (frame_stb) begin
                        packet_id <= packet_id + 32'd1;
                        tx_cnt    <= tx_cnt + 64'd1;
                        remaining <= rem_eval;
                        if (interval != '0) begin
                            gap_cnt   <= interval - 16'd1;
                            seq_state <= SEQ_GAP;
                        end else if (finish) begin
                            seq_state <= SEQ_IDLE;
                        end else begin
                            // Zero gap, next frame right away
                            build_stb <= 1'b1;
                        end
                    end
                end

                SEQ_GAP: begin
                    if (gap_cnt == '0) begin
                        if (finish) begin
                            seq_state <= SEQ_IDLE;
                        end else begin
                            build_stb <= 1'b1;
                            seq_state <= SEQ_SEND;
                        end
                    end else begin
                        gap_cnt <= gap_cnt - 16'd1;
                    end
                end

                default: seq_state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== source/pktgen_top.sv ====
// Single clock domain; the Avalon-MM bus and the byte stream share clk_ifc_avmm.
// Frame size and source MAC come from pktgen_cfg.svh.

`timescale 1ns/1ns

module pktgen_top import pktgen_pkg::*; (
    input  logic        clk_ifc_avmm,
    input  logic        reset,
    input  logic [4:0]  address,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic        read,
    input  logic        tready,
    output logic [31:0] readdata,
    output logic [7:0]  tdata,
    output logic        tvalid,
    output logic        tlast
);

    // Control and status between the register block and the sequencer
    logic        start_stb;
    logic        stop_stb;
    logic        continuous;
    logic [31:0] num_packets;
    logic [15:0] interval;
    seq_state_t  seq_state;
    logic [31:0] remaining;
    logic [63:0] tx_cnt;

    // Sequencer to builder handshake
    logic        build_stb;
    logic        frame_stb;
    logic [31:0] packet_id;

    // Header fields
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [47:0] dst_mac;
    logic [15:0] ident_base;

    pktgen_regs u_regs (
        .clk_ifc_avmm (clk_ifc_avmm),
        .reset        (reset),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .read         (read),
        .seq_state    (seq_state),
        .remaining    (remaining),
        .tx_cnt       (tx_cnt),
        .readdata     (readdata),
        .start_stb    (start_stb),
        .stop_stb     (stop_stb),
        .continuous   (continuous),
        .num_packets  (num_packets),
        .interval     (interval),
        .dscp         (dscp),
        .ecn          (ecn),
        .ttl          (ttl),
        .protocol     (protocol),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .dst_mac      (dst_mac),
        .ident_base   (ident_base)
    );

    pktgen_sequencer u_sequencer (
        .clk_ifc_avmm (clk_ifc_avmm),
        .reset        (reset),
        .start_stb    (start_stb),
        .stop_stb     (stop_stb),
        .continuous   (continuous),
        .num_packets  (num_packets),
        .interval     (interval),
        .frame_stb    (frame_stb),
        .seq_state    (seq_state),
        .remaining    (remaining),
        .tx_cnt       (tx_cnt),
        .build_stb    (build_stb),
        .packet_id    (packet_id)
    );

    ipv4_frame_builder u_builder (
        .clk_ifc_avmm (clk_ifc_avmm),
        .reset        (reset),
        .build_stb    (build_stb),
        .packet_id    (packet_id),
        .dscp         (dscp),
        .ecn          (ecn),
        .ttl          (ttl),
        .protocol     (protocol),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .dst_mac      (dst_mac),
        .ident_base   (ident_base),
        .tready       (tready),
        .frame_stb    (frame_stb),
        .tdata        (tdata),
        .tvalid       (tvalid),
        .tlast        (tlast)
    );

endmodule
